// ==== source/isa_pkg.sv ====
// Reduced PISA instruction set
// Word and register types, opcode and function codes, field positions

package isa_pkg;

  // ------------------------------
  // Types
  // ------------------------------

  typedef logic [31:0] word_t;      // Data or instruction word
  typedef logic [4:0]  reg_addr_t;  // Register specifier
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;       // I-type immediate

  // ------------------------------
  // Field positions
  // ------------------------------

  localparam int OPCODE_LSB = 26;
  localparam int RS_LSB     = 21;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;
  localparam int FUNCT_LSB  = 0;
  localparam int IMM_LSB    = 0;

  // ------------------------------
  // Major opcodes
  // ------------------------------

  localparam opcode_t OP_SPECIAL = 6'd0;   // Register-register group
  localparam opcode_t OP_BNE     = 6'd5;
  localparam opcode_t OP_ADDIU   = 6'd9;
  localparam opcode_t OP_COP0    = 6'd16;  // MFC0 and MTC0

  // Function codes under OP_SPECIAL
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;

  // Sub-op in the rs field of OP_COP0
  localparam reg_addr_t COP0_MF = 5'd0;
  localparam reg_addr_t COP0_MT = 5'd4;

endpackage

// ==== source/pipe_pkg.sv ====
// Pipeline-internal types
// ALU function select and fetch FSM states

package pipe_pkg;

  // ------------------------------
  // ALU functions
  // ------------------------------

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_PASS_B   // Result is operand b unchanged
  } alu_fn_t;

  // ------------------------------
  // Fetch FSM
  // ------------------------------

  typedef enum logic [1:0] {
    FETCH_IDLE,  // No request outstanding
    FETCH_WAIT,  // Request outstanding, response wanted
    FETCH_DROP   // Request outstanding, response to be discarded
  } fetch_state_t;

endpackage

// ==== source/stage_if.sv ====
// Inter-stage interfaces of the pipeline
// Each carries a val/rdy handshake and the payload of one instruction

`timescale 1ns/1ns

interface fd_if;
  logic        val, rdy;
  logic [31:0] inst;
  logic [31:0] pc;    // Address of inst

  modport fetch_side  (output val, inst, pc, input rdy);
  modport decode_side (input val, inst, pc, output rdy);
endinterface

interface dx_if;
  logic                val, rdy;
  pipe_pkg::alu_fn_t   alu_fn;
  logic [31:0]         op_a, op_b;
  logic [4:0]          waddr;
  logic                wen;
  logic                is_bne;
  logic [31:0]         br_target;
  logic                to_mngr;  // Result goes to the manager output

  modport decode_side  (output val, alu_fn, op_a, op_b, waddr, wen, is_bne, br_target,
                        to_mngr, input rdy);
  modport execute_side (input val, alu_fn, op_a, op_b, waddr, wen, is_bne, br_target,
                        to_mngr, output rdy);
endinterface

interface xw_if;
  logic        val, rdy;
  logic [31:0] result;
  logic [4:0]  waddr;
  logic        wen, to_mngr;

  modport execute_side   (output val, result, waddr, wen, to_mngr, input rdy);
  modport writeback_side (input val, result, waddr, wen, to_mngr, output rdy);
  modport monitor        (input val, waddr, wen);  // Hazard check in decode
endinterface

// ==== source/fetch_unit.sv ====
// Fetch stage
// Issues one instruction-memory request at a time and buffers the response

`timescale 1ns/1ns

module fetch_unit #(
  parameter isa_pkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           reset,
  output logic           imem_req_val,
  input  logic           imem_req_rdy,
  output isa_pkg::word_t imem_req_addr,
  input  logic           imem_resp_val,
  output logic           imem_resp_rdy,
  input  isa_pkg::word_t imem_resp_data,
  input  logic           redirect,
  input  isa_pkg::word_t redirect_pc,
  fd_if.fetch_side       fd
);

  pipe_pkg::fetch_state_t state;
  isa_pkg::word_t         pc;         // Address of the request being issued or in flight
  logic                   fd_room;
  logic                   req_fire;
  logic                   resp_fire;
  logic                   keep_resp;  // Response goes into the fd register

  assign fd_room       = !fd.val || fd.rdy;
  assign imem_req_val  = !reset && (state == pipe_pkg::FETCH_IDLE) && fd_room;
  assign imem_req_addr = pc;
  assign req_fire      = imem_req_val && imem_req_rdy;

  always_comb begin
    case (state)
      pipe_pkg::FETCH_WAIT: imem_resp_rdy = fd_room;
      pipe_pkg::FETCH_DROP: imem_resp_rdy = 1'b1;  // Stale response is always taken
      default:              imem_resp_rdy = 1'b0;
    endcase
  end

  assign resp_fire = imem_resp_val && imem_resp_rdy;
  assign keep_resp = resp_fire && (state == pipe_pkg::FETCH_WAIT) && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= pipe_pkg::FETCH_IDLE;
      pc     <= RESET_PC;
      fd.val <= 1'b0;
    end else begin
      case (state)
        pipe_pkg::FETCH_IDLE: if (req_fire) state <= redirect ? pipe_pkg::FETCH_DROP
                                                              : pipe_pkg::FETCH_WAIT;
        pipe_pkg::FETCH_WAIT: begin
          if (resp_fire)     state <= pipe_pkg::FETCH_IDLE;  // Discarded if redirect
          else if (redirect) state <= pipe_pkg::FETCH_DROP;
        end
        pipe_pkg::FETCH_DROP: if (resp_fire) state <= pipe_pkg::FETCH_IDLE;
        default:              state <= pipe_pkg::FETCH_IDLE;
      endcase

      if (redirect)       pc <= redirect_pc;
      else if (keep_resp) pc <= pc + 32'd4;

      // Squash on a taken branch
      if (redirect)       fd.val <= 1'b0;
      else if (keep_resp) fd.val <= 1'b1;
      else if (fd.rdy)    fd.val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (keep_resp) begin
      fd.inst <= imem_resp_data;
      fd.pc   <= pc;
    end
  end

endmodule

// ==== source/decode_unit.sv ====
// Decode stage
// Control table, operand read, hazard and manager-input stalls, dx register

`timescale 1ns/1ns

module decode_unit (
  input  logic              clk,
  input  logic              reset,
  fd_if.decode_side         fd,
  dx_if.decode_side         dx,
  xw_if.monitor             xw_mon,
  input  logic              redirect,
  output isa_pkg::reg_addr_t rs_addr,
  output isa_pkg::reg_addr_t rt_addr,
  input  isa_pkg::word_t    rs_data,
  input  isa_pkg::word_t    rt_data,
  input  logic              from_mngr_val,
  output logic              from_mngr_rdy,
  input  isa_pkg::word_t    from_mngr_data
);

  // Operand b sources
  localparam logic [1:0] B_RT   = 2'd0;
  localparam logic [1:0] B_IMM  = 2'd1;
  localparam logic [1:0] B_MNGR = 2'd2;

  isa_pkg::opcode_t   opcode;
  isa_pkg::funct_t    funct;
  isa_pkg::reg_addr_t rd;
  isa_pkg::imm_t      imm;
  isa_pkg::word_t     sext_imm;

  pipe_pkg::alu_fn_t  alu_fn_d;
  logic [1:0]         b_sel;
  logic               rs_en, rt_en;
  logic               wen_d, is_bne_d, to_mngr_d, mfc0_d;
  isa_pkg::reg_addr_t waddr_d;
  isa_pkg::word_t     op_b_d;

  logic hazard, mngr_stall, dx_free, load_dx;

  // Reg-file writer still in flight for this source
  function automatic logic pending(isa_pkg::reg_addr_t src, logic val, logic wen,
                                   isa_pkg::reg_addr_t waddr);
    return val && wen && (waddr != '0) && (waddr == src);
  endfunction

  // ------------------------------
  // Fields
  // ------------------------------

  assign opcode   = fd.inst[isa_pkg::OPCODE_LSB +: $bits(isa_pkg::opcode_t)];
  assign funct    = fd.inst[isa_pkg::FUNCT_LSB +: $bits(isa_pkg::funct_t)];
  assign rs_addr  = fd.inst[isa_pkg::RS_LSB +: $bits(isa_pkg::reg_addr_t)];
  assign rt_addr  = fd.inst[isa_pkg::RT_LSB +: $bits(isa_pkg::reg_addr_t)];
  assign rd       = fd.inst[isa_pkg::RD_LSB +: $bits(isa_pkg::reg_addr_t)];
  assign imm      = fd.inst[isa_pkg::IMM_LSB +: $bits(isa_pkg::imm_t)];
  assign sext_imm = {{16{imm[15]}}, imm};

  // ------------------------------
  // Control table
  // ------------------------------

  always_comb begin
    alu_fn_d  = pipe_pkg::ALU_ADD;
    b_sel     = B_RT;
    rs_en     = 1'b0;
    rt_en     = 1'b0;
    wen_d     = 1'b0;
    waddr_d   = rd;
    is_bne_d  = 1'b0;
    to_mngr_d = 1'b0;
    mfc0_d    = 1'b0;
    case (opcode)
      isa_pkg::OP_SPECIAL: begin
        rs_en = 1'b1;
        rt_en = 1'b1;
        wen_d = 1'b1;
        case (funct)
          isa_pkg::FN_ADDU: alu_fn_d = pipe_pkg::ALU_ADD;
          isa_pkg::FN_SUBU: alu_fn_d = pipe_pkg::ALU_SUB;
          isa_pkg::FN_AND:  alu_fn_d = pipe_pkg::ALU_AND;
          isa_pkg::FN_OR:   alu_fn_d = pipe_pkg::ALU_OR;
          default: begin   // NOP and unsupported functions retire silently
            rs_en = 1'b0;
            rt_en = 1'b0;
            wen_d = 1'b0;
          end
        endcase
      end
      isa_pkg::OP_ADDIU: begin
        rs_en   = 1'b1;
        b_sel   = B_IMM;
        wen_d   = 1'b1;
        waddr_d = rt_addr;
      end
      isa_pkg::OP_BNE: begin
        rs_en    = 1'b1;
        rt_en    = 1'b1;
        alu_fn_d = pipe_pkg::ALU_SUB;
        is_bne_d = 1'b1;
      end
      isa_pkg::OP_COP0: begin
        alu_fn_d = pipe_pkg::ALU_PASS_B;
        if (rs_addr == isa_pkg::COP0_MF) begin
          b_sel   = B_MNGR;
          wen_d   = 1'b1;
          waddr_d = rt_addr;
          mfc0_d  = 1'b1;
        end else if (rs_addr == isa_pkg::COP0_MT) begin
          rt_en     = 1'b1;
          to_mngr_d = 1'b1;
        end
      end
      default: ;  // Invalid encodings pass down with no effect
    endcase
  end

  always_comb begin
    case (b_sel)
      B_IMM:   op_b_d = sext_imm;
      B_MNGR:  op_b_d = from_mngr_data;
      default: op_b_d = rt_data;
    endcase
  end

  // ------------------------------
  // Stalls and handshake
  // ------------------------------

  assign hazard = (rs_en && (pending(rs_addr, dx.val, dx.wen, dx.waddr) ||
                             pending(rs_addr, xw_mon.val, xw_mon.wen, xw_mon.waddr))) ||
                  (rt_en && (pending(rt_addr, dx.val, dx.wen, dx.waddr) ||
                             pending(rt_addr, xw_mon.val, xw_mon.wen, xw_mon.waddr)));

  assign mngr_stall    = mfc0_d && !from_mngr_val;
  assign dx_free       = !dx.val || dx.rdy;
  assign fd.rdy        = dx_free && !hazard && !mngr_stall;
  assign load_dx       = fd.val && fd.rdy && !redirect;  // Squashed on a taken branch
  assign from_mngr_rdy = load_dx && mfc0_d;

  always_ff @(posedge clk) begin
    if (reset)        dx.val <= 1'b0;
    else if (load_dx) dx.val <= 1'b1;
    else if (dx.rdy)  dx.val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (load_dx) begin
      dx.alu_fn    <= alu_fn_d;
      dx.op_a      <= rs_data;
      dx.op_b      <= op_b_d;
      dx.waddr     <= waddr_d;
      dx.wen       <= wen_d;
      dx.is_bne    <= is_bne_d;
      dx.br_target <= fd.pc + 32'd4 + {sext_imm[29:0], 2'b00};
      dx.to_mngr   <= to_mngr_d;
    end
  end

endmodule

// ==== source/reg_file.sv ====
// Register file
// 32 words, two combinational reads, one clocked write, r0 reads zero

`timescale 1ns/1ns

module reg_file (
  input  logic               clk,
  input  isa_pkg::reg_addr_t rs_addr,
  input  isa_pkg::reg_addr_t rt_addr,
  output isa_pkg::word_t     rs_data,
  output isa_pkg::word_t     rt_data,
  input  logic               wen,
  input  isa_pkg::reg_addr_t waddr,
  input  isa_pkg::word_t     wdata
);

  isa_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) regs[waddr] <= wdata;
  end

  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== source/execute_unit.sv ====
// Execute stage
// ALU, BNE resolution with redirect, xw register

`timescale 1ns/1ns

module execute_unit (
  input  logic           clk,
  input  logic           reset,
  dx_if.execute_side     dx,
  xw_if.execute_side     xw,
  output logic           redirect,
  output isa_pkg::word_t redirect_pc
);

  logic           fire;
  logic           taken;
  isa_pkg::word_t alu_out;

  assign dx.rdy = !xw.val || xw.rdy;
  assign fire   = dx.val && dx.rdy;

  // ------------------------------
  // ALU
  // ------------------------------

  always_comb begin
    case (dx.alu_fn)
      pipe_pkg::ALU_ADD: alu_out = dx.op_a + dx.op_b;  // Wraps at 32 bits
      pipe_pkg::ALU_SUB: alu_out = dx.op_a - dx.op_b;
      pipe_pkg::ALU_AND: alu_out = dx.op_a & dx.op_b;
      pipe_pkg::ALU_OR:  alu_out = dx.op_a | dx.op_b;
      default:           alu_out = dx.op_b;
    endcase
  end

  // Branch resolves while the BNE leaves dx
  assign taken       = dx.is_bne && (dx.op_a != dx.op_b);
  assign redirect    = fire && taken;
  assign redirect_pc = dx.br_target;

  always_ff @(posedge clk) begin
    if (reset)       xw.val <= 1'b0;
    else if (fire)   xw.val <= 1'b1;
    else if (xw.rdy) xw.val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      xw.result  <= alu_out;
      xw.waddr   <= dx.waddr;
      xw.wen     <= dx.wen;
      xw.to_mngr <= dx.to_mngr;
    end
  end

endmodule

// ==== source/writeback_unit.sv ====
// Writeback stage
// Register-file write or manager output, holds xw while the manager refuses

`timescale 1ns/1ns

module writeback_unit (
  xw_if.writeback_side        xw,
  output logic               rf_wen,
  output isa_pkg::reg_addr_t rf_waddr,
  output isa_pkg::word_t     rf_wdata,
  output logic               to_mngr_val,
  input  logic               to_mngr_rdy,
  output isa_pkg::word_t     to_mngr_data
);

  logic fire;

  // Only an MTC0 can be held back
  assign xw.rdy = !xw.to_mngr || to_mngr_rdy;
  assign fire   = xw.val && xw.rdy;

  // ------------------------------
  // Register file
  // ------------------------------

  assign rf_wen   = fire && xw.wen;
  assign rf_waddr = xw.waddr;
  assign rf_wdata = xw.result;

  // ------------------------------
  // Manager output
  // ------------------------------

  assign to_mngr_val  = xw.val && xw.to_mngr;
  assign to_mngr_data = xw.result;

endmodule

// ==== source/pisa_stall_pipe.sv ====
// Four-stage stall-only PISA pipeline
// Fetch, decode, execute and writeback with val/rdy streams at the ports

`timescale 1ns/1ns

module pisa_stall_pipe #(
  parameter isa_pkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           reset,
  output logic           imem_req_val,
  input  logic           imem_req_rdy,
  output isa_pkg::word_t imem_req_addr,
  input  logic           imem_resp_val,
  output logic           imem_resp_rdy,
  input  isa_pkg::word_t imem_resp_data,
  input  logic           from_mngr_val,
  output logic           from_mngr_rdy,
  input  isa_pkg::word_t from_mngr_data,
  output logic           to_mngr_val,
  input  logic           to_mngr_rdy,
  output isa_pkg::word_t to_mngr_data
);

  fd_if fd ();
  dx_if dx ();
  xw_if xw ();

  logic               redirect;
  isa_pkg::word_t     redirect_pc;
  logic               rf_wen;
  isa_pkg::reg_addr_t rf_waddr;
  isa_pkg::word_t     rf_wdata;
  isa_pkg::reg_addr_t rs_addr, rt_addr;
  isa_pkg::word_t     rs_data, rt_data;

  // ------------------------------
  // Input side
  // ------------------------------

  fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
    .clk, .reset,
    .imem_req_val, .imem_req_rdy, .imem_req_addr,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_data,
    .redirect, .redirect_pc,
    .fd (fd.fetch_side)
  );

  // ------------------------------
  // Processing
  // ------------------------------

  decode_unit decode_unit_i (
    .clk, .reset,
    .fd (fd.decode_side), .dx (dx.decode_side), .xw_mon (xw.monitor),
    .redirect,
    .rs_addr, .rt_addr, .rs_data, .rt_data,
    .from_mngr_val, .from_mngr_rdy, .from_mngr_data
  );

  reg_file reg_file_i (
    .clk, .rs_addr, .rt_addr, .rs_data, .rt_data,
    .wen (rf_wen), .waddr (rf_waddr), .wdata (rf_wdata)
  );

  execute_unit execute_unit_i (
    .clk, .reset,
    .dx (dx.execute_side), .xw (xw.execute_side),
    .redirect, .redirect_pc
  );

  // Output side
  writeback_unit writeback_unit_i (
    .xw (xw.writeback_side),
    .rf_wen, .rf_waddr, .rf_wdata,
    .to_mngr_val, .to_mngr_rdy, .to_mngr_data
  );

endmodule

// ==== verification/pisa_stall_pipe_tb.sv ====
// Testbench for the four-stage stall-only PISA pipeline
// Instruction memory and manager models with directed program tests

`timescale 1ns/1ns

module pisa_stall_pipe_tb;

  localparam int MEM_WORDS      = 256;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int DRAIN_CYCLES   = 100;  // Idle watch for extra outputs
  localparam int LOOP_COUNT     = 5;
  localparam int SEED           = 38843;

  logic           clk            = 1'b0;
  logic           reset          = 1'b1;
  logic           imem_req_val;
  logic           imem_req_rdy   = 1'b0;
  isa_pkg::word_t imem_req_addr;
  logic           imem_resp_val  = 1'b0;
  logic           imem_resp_rdy;
  isa_pkg::word_t imem_resp_data = '0;
  logic           from_mngr_val  = 1'b0;
  logic           from_mngr_rdy;
  isa_pkg::word_t from_mngr_data = '0;
  logic           to_mngr_val;
  logic           to_mngr_rdy    = 1'b0;
  isa_pkg::word_t to_mngr_data;

  isa_pkg::word_t imem [MEM_WORDS];
  isa_pkg::word_t prog[$], src_q[$], exp_q[$], sink_q[$];
  int             src_rate;   // Percent of cycles with from_mngr_val offered
  int             sink_rate;  // Percent of cycles with to_mngr_rdy high
  int             src_pos;
  int             errors = 0;
  int             checks = 0;
  int             seed_val;
  logic           mem_busy;
  isa_pkg::word_t mem_addr;
  int             mem_wait;

  always #2 clk = ~clk;

  pisa_stall_pipe #(.RESET_PC(32'h0)) pisa_stall_pipe_i (.*);

  // ------------------------------
  // Assembler
  // ------------------------------

  function automatic isa_pkg::word_t encode(isa_pkg::opcode_t op, isa_pkg::reg_addr_t rs,
                                            isa_pkg::reg_addr_t rt, isa_pkg::reg_addr_t rd,
                                            logic [15:0] low);
    return (32'(op) << isa_pkg::OPCODE_LSB) | (32'(rs) << isa_pkg::RS_LSB) |
           (32'(rt) << isa_pkg::RT_LSB) | (32'(rd) << isa_pkg::RD_LSB) | 32'(low);
  endfunction

  function automatic isa_pkg::word_t alu_rr(isa_pkg::funct_t fn, isa_pkg::reg_addr_t rd,
                                            isa_pkg::reg_addr_t rs, isa_pkg::reg_addr_t rt);
    return encode(isa_pkg::OP_SPECIAL, rs, rt, rd, 16'(fn));
  endfunction

  function automatic isa_pkg::word_t addiu(isa_pkg::reg_addr_t rt, isa_pkg::reg_addr_t rs,
                                           logic [15:0] imm);
    return encode(isa_pkg::OP_ADDIU, rs, rt, 5'd0, imm);
  endfunction

  function automatic isa_pkg::word_t bne(isa_pkg::reg_addr_t rs, isa_pkg::reg_addr_t rt,
                                         logic [15:0] offset);
    return encode(isa_pkg::OP_BNE, rs, rt, 5'd0, offset);  // Offset in words from pc+4
  endfunction

  function automatic isa_pkg::word_t mfc0(isa_pkg::reg_addr_t rt);
    return encode(isa_pkg::OP_COP0, isa_pkg::COP0_MF, rt, 5'd0, 16'd0);
  endfunction

  function automatic isa_pkg::word_t mtc0(isa_pkg::reg_addr_t rt);
    return encode(isa_pkg::OP_COP0, isa_pkg::COP0_MT, rt, 5'd0, 16'd0);
  endfunction

  // Invalid opcode so a runaway fetch retires with no effect
  function automatic isa_pkg::word_t fill_word(isa_pkg::word_t addr);
    return {6'h3f, addr[27:2] ^ {20'd0, addr[31:28], addr[1:0]}};
  endfunction

  function automatic isa_pkg::word_t read_word(isa_pkg::word_t addr);
    if ((addr >> 2) < MEM_WORDS) return imem[addr[9:2]];
    return fill_word(addr);
  endfunction

  function automatic void emit(isa_pkg::word_t inst, int gap);
    prog.push_back(inst);
    repeat (gap) prog.push_back('0);  // NOPs
  endfunction

  // ------------------------------
  // Memory and manager models
  // ------------------------------

  always @(posedge clk) begin
    if (reset) begin
      imem_req_rdy  <= 1'b0;
      imem_resp_val <= 1'b0;
      mem_busy = 1'b0;
    end else begin
      imem_req_rdy <= 1'b1;
      if (imem_resp_val && imem_resp_rdy) begin
        imem_resp_val <= 1'b0;
        mem_busy = 1'b0;
      end else if (mem_busy && !imem_resp_val) begin
        if (mem_wait == 0) begin
          imem_resp_val  <= 1'b1;
          imem_resp_data <= read_word(mem_addr);
        end else begin
          mem_wait--;
        end
      end
      if (imem_req_val && imem_req_rdy) begin
        mem_busy = 1'b1;
        mem_addr = imem_req_addr;
        mem_wait = $urandom_range(3, 0);  // Extra latency
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      from_mngr_val <= 1'b0;
      src_pos = 0;
    end else begin
      if (from_mngr_val && from_mngr_rdy) src_pos++;
      if (!from_mngr_val || from_mngr_rdy) begin  // Offered word holds until taken
        from_mngr_val <= (src_pos < src_q.size()) && ($urandom_range(99, 0) < src_rate);
        if (src_pos < src_q.size()) from_mngr_data <= src_q[src_pos];
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      to_mngr_rdy <= 1'b0;
    end else begin
      if (to_mngr_val && to_mngr_rdy) sink_q.push_back(to_mngr_data);
      to_mngr_rdy <= $urandom_range(99, 0) < sink_rate;
    end
  end

  // ------------------------------
  // Test sequencing
  // ------------------------------

  task automatic new_test(input int src_pct, input int sink_pct);
    prog.delete();
    src_q.delete();
    exp_q.delete();
    src_rate  = src_pct;
    sink_rate = sink_pct;
  endtask

  task automatic reset_and_load();
    reset <= 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) imem[i] = fill_word(32'(i) << 2);
    foreach (prog[i]) imem[i] = prog[i];
    repeat (10) @(posedge clk);
    sink_q.delete();
    reset <= 1'b0;
  endtask

  task automatic run_check(input string name);
    int cycles;
    reset_and_load();
    cycles = 0;
    while (sink_q.size() < exp_q.size() && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    checks++;
    assert (sink_q.size() >= exp_q.size())
      else begin
        $display("%s timed out with %0d of %0d outputs received", name, sink_q.size(),
                 exp_q.size());
        errors++;
      end
    repeat (DRAIN_CYCLES) @(posedge clk);  // A squashed MTC0 would show up here
    checks++;
    assert (sink_q.size() == exp_q.size())
      else begin
        $display("ERROR %s: output count expected %0d, actual %0d", name, exp_q.size(),
                 sink_q.size());
        errors++;
      end
    foreach (exp_q[i]) begin
      if (i < sink_q.size()) begin
        checks++;
        assert (sink_q[i] === exp_q[i])
          else begin
            $display("ERROR %s: output %0d expected %h, actual %h", name, i, exp_q[i],
                     sink_q[i]);
            errors++;
          end
      end
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic echo_test(input string name, input int src_pct, input int sink_pct);
    isa_pkg::word_t w;
    new_test(src_pct, sink_pct);
    emit(addiu(2, 0, 16'd1), 0);
    emit(mfc0(1), 0);
    emit(mtc0(1), 0);
    emit(bne(2, 0, 16'(-3)), 0);  // Back to the MFC0
    repeat (8) begin
      w = $urandom;
      src_q.push_back(w);
      exp_q.push_back(w);
    end
    run_check(name);
  endtask

  task automatic alu_test();
    isa_pkg::word_t a, b, sext;
    logic [15:0]    imm;
    new_test(70, 80);
    a    = $urandom;
    b    = $urandom;
    imm  = 16'($urandom);
    sext = {{16{imm[15]}}, imm};
    src_q.push_back(a);
    src_q.push_back(b);
    emit(mfc0(1), 3);
    emit(mfc0(2), 3);
    emit(alu_rr(isa_pkg::FN_ADDU, 3, 1, 2), 3);
    emit(alu_rr(isa_pkg::FN_SUBU, 4, 1, 2), 3);
    emit(alu_rr(isa_pkg::FN_AND, 5, 1, 2), 3);
    emit(alu_rr(isa_pkg::FN_OR, 6, 1, 2), 3);
    emit(addiu(7, 1, imm), 3);
    for (int r = 3; r <= 7; r++) emit(mtc0(5'(r)), 3);
    exp_q.push_back(a + b);
    exp_q.push_back(a - b);
    exp_q.push_back(a & b);
    exp_q.push_back(a | b);
    exp_q.push_back(a + sext);
    run_check("alu");
  endtask

  // Each op reads the previous result back to back
  task automatic chain_test();
    isa_pkg::word_t a, b, c, v;
    logic [15:0]    imm;
    new_test(90, 90);
    a   = $urandom;
    b   = $urandom;
    c   = $urandom;
    imm = 16'($urandom);
    src_q.push_back(a);
    src_q.push_back(b);
    src_q.push_back(c);
    emit(mfc0(1), 0);
    emit(mfc0(2), 0);
    emit(mfc0(8), 0);
    emit(alu_rr(isa_pkg::FN_ADDU, 3, 1, 2), 0);
    emit(mtc0(3), 0);
    emit(alu_rr(isa_pkg::FN_SUBU, 4, 3, 8), 0);
    emit(mtc0(4), 0);
    emit(alu_rr(isa_pkg::FN_AND, 5, 4, 1), 0);
    emit(mtc0(5), 0);
    emit(alu_rr(isa_pkg::FN_OR, 6, 5, 8), 0);
    emit(mtc0(6), 0);
    emit(addiu(7, 6, imm), 0);
    emit(mtc0(7), 0);
    v = a + b;
    exp_q.push_back(v);
    v = v - c;
    exp_q.push_back(v);
    v = v & a;
    exp_q.push_back(v);
    v = v | c;
    exp_q.push_back(v);
    v = v + {{16{imm[15]}}, imm};
    exp_q.push_back(v);
    run_check("hazard_chain");
  endtask

  task automatic branch_test();
    new_test(80, 80);
    emit(addiu(1, 0, 16'(LOOP_COUNT)), 0);
    emit(addiu(2, 0, 16'h0bad), 0);  // Poison value
    emit(addiu(3, 0, 16'h600d), 0);  // Exit marker
    emit(mtc0(1), 0);                // Loop head at 12
    emit(addiu(1, 1, 16'(-1)), 0);
    emit(bne(1, 0, 16'(-3)), 0);
    emit(mtc0(3), 0);                // Only after the untaken branch
    emit(bne(3, 0, 16'(-1)), 0);     // Spin forever
    emit(mtc0(2), 0);
    for (int i = LOOP_COUNT; i >= 1; i--) exp_q.push_back(32'(i));
    exp_q.push_back(32'h0000_600d);
    run_check("branch");
  endtask

  initial begin
    seed_val = $urandom(SEED);
    echo_test("echo", 60, 80);
    alu_test();
    chain_test();
    branch_test();
    echo_test("back_pressure", 20, 30);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== pisa_stall_pipe.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/stage_if.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/writeback_unit.sv
source/pisa_stall_pipe.sv
verification/pisa_stall_pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
verilator --binary --timing --top-module pisa_stall_pipe_tb -f pisa_stall_pipe.f \
  -o pisa_stall_pipe_sim || exit 1
./obj_dir/pisa_stall_pipe_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
